// File: logic/regwin_pkg.sv
// sizes and window mapping constants for the windowed register file
`default_nettype none

package regwin_pkg;

	// data word
	localparam int REG_WIDTH = 32;

	// window geometry
	localparam int NUM_WINDOWS = 4;
	localparam int WIN_BITS = $clog2(NUM_WINDOWS);
	localparam int VIS_REGS = 32;
	localparam int ADDR_BITS = $clog2(VIS_REGS);

	// physical storage is built from banks of eight
	localparam int BANK_REGS = 8;
	localparam int BANK_IDX_BITS = $clog2(BANK_REGS);

	// globals sit below the windowed region
	localparam int GLOBAL_REGS = 8;

	// adjacent windows share eight registers, so each step moves 16
	localparam int WINDOW_STRIDE = 16;
	localparam int WINDOWED_REGS = NUM_WINDOWS * WINDOW_STRIDE;

	// 72 physical registers in total
	localparam int NUM_BANKS = (GLOBAL_REGS + WINDOWED_REGS) / BANK_REGS;
	localparam int BANK_BITS = $clog2(NUM_BANKS);

endpackage

`default_nettype wire

// File: logic/window_control.sv
// current window pointer and window invalid mask
// save/restore moves with a registered trap on a blocked move
`timescale 1ns/1ns
`default_nettype none

module window_control (
	input  logic                                 Clk,
	input  logic                                 arst_n,
	input  logic                                 save,
	input  logic                                 restore,
	input  logic                                 wim_write,
	input  logic [regwin_pkg::NUM_WINDOWS-1:0]   wim_data,
	output logic [regwin_pkg::WIN_BITS-1:0]      cwp,
	output logic                                 window_trap
);

	logic [regwin_pkg::NUM_WINDOWS-1:0] wim;
	logic [regwin_pkg::WIN_BITS-1:0]    target;
	logic                               move_req;
	logic                               blocked;

	assign move_req = save | restore;

	// save steps down, restore steps up, save wins if both arrive
	always_comb begin
		if (save) begin
			target = cwp - 1'b1;
		end else begin
			target = cwp + 1'b1;
		end
	end

	// a marked window refuses the move
	assign blocked = wim[target];

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			cwp         <= '0;
			wim         <= '0;
			window_trap <= 1'b0;
		end else begin
			window_trap <= move_req & blocked;
			if (move_req && !blocked) begin
				cwp <= target;
			end
			// new mask only affects moves from the next cycle on
			if (wim_write) begin
				wim <= wim_data;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/window_decoder.sv
// window address decoder
// maps window and r_num to bank and index, gives write enables and read select
`timescale 1ns/1ns
`default_nettype none

module window_decoder (
	input  logic [regwin_pkg::WIN_BITS-1:0]      cwp,
	input  logic [regwin_pkg::ADDR_BITS-1:0]     r_num,
	input  logic                                 enable,
	input  logic                                 rw,
	output logic [regwin_pkg::NUM_BANKS-1:0]     bank_we,
	output logic [regwin_pkg::BANK_IDX_BITS-1:0] wr_idx,
	output logic [regwin_pkg::BANK_BITS-1:0]     rd_bank,
	output logic [regwin_pkg::BANK_IDX_BITS-1:0] rd_idx,
	output logic                                 rd_active
);

	// physical register number, 0 to 71
	int unsigned phys;
	logic        write_req;

	always_comb begin
		if (32'(r_num) < regwin_pkg::GLOBAL_REGS) begin
			// globals are shared by every window
			phys = 32'(r_num);
		end else begin
			// windowed region wraps, so window 3 ins land on physical 8..15
			phys = regwin_pkg::GLOBAL_REGS
				+ (32'(cwp) * regwin_pkg::WINDOW_STRIDE + 32'(r_num)
				- regwin_pkg::GLOBAL_REGS) % regwin_pkg::WINDOWED_REGS;
		end
	end

	// bank number is the upper part, index the lower three bits
	assign rd_bank = phys[regwin_pkg::BANK_IDX_BITS +: regwin_pkg::BANK_BITS];
	assign rd_idx  = phys[regwin_pkg::BANK_IDX_BITS-1:0];
	assign wr_idx  = rd_idx;

	// r0 is never written
	assign write_req = enable & rw & (r_num != '0);
	assign rd_active = enable & ~rw;

	// one-hot write enable for the addressed bank
	always_comb begin
		for (int b = 0; b < regwin_pkg::NUM_BANKS; b++) begin
			bank_we[b] = write_req && (32'(rd_bank) == b);
		end
	end

endmodule

`default_nettype wire

// File: logic/register_bank.sv
// bank of eight 32-bit registers with a single write port
`timescale 1ns/1ns
`default_nettype none

module register_bank (
	input  logic                                                Clk,
	input  logic                                                arst_n,
	input  logic                                                we,
	input  logic [regwin_pkg::BANK_IDX_BITS-1:0]                idx,
	input  logic [regwin_pkg::REG_WIDTH-1:0]                    wdata,
	output logic [regwin_pkg::BANK_REGS*regwin_pkg::REG_WIDTH-1:0] rdata
);

	// register 0 of the array sits in the low word of rdata
	logic [regwin_pkg::BANK_REGS-1:0][regwin_pkg::REG_WIDTH-1:0] regs;

	always_ff @(posedge Clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '0;
		end else if (we) begin
			regs[idx] <= wdata;
		end
	end

	// all eight words go out in parallel
	assign rdata = regs;

endmodule

`default_nettype wire

// File: logic/read_select.sv
// read multiplexer over all banks, bank first and then word
// output is zero unless a read is in progress
`timescale 1ns/1ns
`default_nettype none

module read_select (
	input  logic [regwin_pkg::NUM_BANKS*regwin_pkg::BANK_REGS*regwin_pkg::REG_WIDTH-1:0]
	                                             bank_data,
	input  logic [regwin_pkg::BANK_BITS-1:0]     rd_bank,
	input  logic [regwin_pkg::BANK_IDX_BITS-1:0] rd_idx,
	input  logic                                 rd_active,
	output logic [regwin_pkg::REG_WIDTH-1:0]     out
);

	logic [regwin_pkg::BANK_REGS*regwin_pkg::REG_WIDTH-1:0] bank_word;
	logic [regwin_pkg::REG_WIDTH-1:0]                       word;

	// bank level, unused bank codes read as zero
	always_comb begin
		bank_word = '0;
		for (int b = 0; b < regwin_pkg::NUM_BANKS; b++) begin
			if (32'(rd_bank) == b) begin
				bank_word = bank_data[b*regwin_pkg::BANK_REGS*regwin_pkg::REG_WIDTH
					+: regwin_pkg::BANK_REGS*regwin_pkg::REG_WIDTH];
			end
		end
	end

	// word level
	assign word = bank_word[rd_idx*regwin_pkg::REG_WIDTH +: regwin_pkg::REG_WIDTH];

	// zero instead of a floating bus when idle or writing
	assign out = rd_active ? word : '0;

endmodule

`default_nettype wire

// File: logic/regwin_top.sv
// windowed register file top level
// window control, decoder, nine register banks and read selector
`timescale 1ns/1ns
`default_nettype none

module regwin_top (
	input  logic                               Clk,
	input  logic                               arst_n,
	input  logic [regwin_pkg::REG_WIDTH-1:0]   in,
	input  logic                               enable,
	input  logic                               rw,
	input  logic [regwin_pkg::ADDR_BITS-1:0]   r_num,
	input  logic                               save,
	input  logic                               restore,
	input  logic                               wim_write,
	input  logic [regwin_pkg::NUM_WINDOWS-1:0] wim_data,
	output logic [regwin_pkg::REG_WIDTH-1:0]   out,
	output logic [regwin_pkg::WIN_BITS-1:0]    current_window,
	output logic                               window_trap
);

	logic [regwin_pkg::WIN_BITS-1:0]      cwp;
	logic [regwin_pkg::NUM_BANKS-1:0]     bank_we;
	logic [regwin_pkg::BANK_IDX_BITS-1:0] wr_idx;
	logic [regwin_pkg::BANK_BITS-1:0]     rd_bank;
	logic [regwin_pkg::BANK_IDX_BITS-1:0] rd_idx;
	logic                                 rd_active;
	// 9 banks x 8 words x 32 bits
	logic [regwin_pkg::NUM_BANKS*regwin_pkg::BANK_REGS*regwin_pkg::REG_WIDTH-1:0] bank_data;

	assign current_window = cwp;

	window_control u_ctrl (
		.Clk         (Clk),
		.arst_n      (arst_n),
		.save        (save),
		.restore     (restore),
		.wim_write   (wim_write),
		.wim_data    (wim_data),
		.cwp         (cwp),
		.window_trap (window_trap)
	);

	window_decoder u_dec (
		.cwp       (cwp),
		.r_num     (r_num),
		.enable    (enable),
		.rw        (rw),
		.bank_we   (bank_we),
		.wr_idx    (wr_idx),
		.rd_bank   (rd_bank),
		.rd_idx    (rd_idx),
		.rd_active (rd_active)
	);

	// bank 0 holds the globals, banks 1..8 the windowed region
	genvar g;
	generate
		for (g = 0; g < regwin_pkg::NUM_BANKS; g++) begin : g_bank
			register_bank u_bank (
				.Clk    (Clk),
				.arst_n (arst_n),
				.we     (bank_we[g]),
				.idx    (wr_idx),
				.wdata  (in),
				.rdata  (bank_data[g*regwin_pkg::BANK_REGS*regwin_pkg::REG_WIDTH
					+: regwin_pkg::BANK_REGS*regwin_pkg::REG_WIDTH])
			);
		end
	endgenerate

	read_select u_sel (
		.bank_data (bank_data),
		.rd_bank   (rd_bank),
		.rd_idx    (rd_idx),
		.rd_active (rd_active),
		.out       (out)
	);

endmodule

`default_nettype wire

// File: verification/regwin_checker.sv
// concurrent assertions on trap timing and read gating, bound into regwin_top
`timescale 1ns/1ns
`default_nettype none

module regwin_checker (
	input logic                             Clk,
	input logic                             arst_n,
	input logic                             enable,
	input logic                             rw,
	input logic [regwin_pkg::ADDR_BITS-1:0] r_num,
	input logic [regwin_pkg::REG_WIDTH-1:0] out,
	input logic [regwin_pkg::WIN_BITS-1:0]  current_window,
	input logic                             window_trap
);

	// a blocked move traps for one cycle only
	a_trap_single: assert property (@(posedge Clk) disable iff (!arst_n)
		window_trap |=> !window_trap)
		else $error("window_trap high for two cycles in a row");

	// pointer holds when the move was refused
	a_trap_holds_window: assert property (@(posedge Clk) disable iff (!arst_n)
		window_trap |-> $stable(current_window))
		else $error("current_window moved on a trapped save or restore");

	a_out_idle_zero: assert property (@(posedge Clk) disable iff (!arst_n)
		(!enable || rw) |-> (out == '0))
		else $error("out not zero while no read is in progress");

	a_r0_zero: assert property (@(posedge Clk) disable iff (!arst_n)
		(enable && !rw && r_num == '0) |-> (out == '0))
		else $error("read of r0 returned a nonzero value");

endmodule

bind regwin_top regwin_checker u_checker (
	.Clk            (Clk),
	.arst_n         (arst_n),
	.enable         (enable),
	.rw             (rw),
	.r_num          (r_num),
	.out            (out),
	.current_window (current_window),
	.window_trap    (window_trap)
);

`default_nettype wire

// File: verification/regwin_tb.sv
// testbench for the windowed register file
// reset sweep, pattern replay and random traffic against a register model
`timescale 1ns/1ns
`default_nettype none

module regwin_tb;

	localparam int NUM_PHYS = regwin_pkg::GLOBAL_REGS + regwin_pkg::WINDOWED_REGS;

	logic                               Clk;
	logic                               arst_n;
	logic [regwin_pkg::REG_WIDTH-1:0]   in;
	logic                               enable;
	logic                               rw;
	logic [regwin_pkg::ADDR_BITS-1:0]   r_num;
	logic                               save;
	logic                               restore;
	logic                               wim_write;
	logic [regwin_pkg::NUM_WINDOWS-1:0] wim_data;
	logic [regwin_pkg::REG_WIDTH-1:0]   out;
	logic [regwin_pkg::WIN_BITS-1:0]    current_window;
	logic                               window_trap;

	// reference model of the 72 physical registers and the window state
	logic [regwin_pkg::REG_WIDTH-1:0]   model_regs [NUM_PHYS];
	int unsigned                        model_win;
	logic [regwin_pkg::NUM_WINDOWS-1:0] model_wim;
	logic                               model_trap;

	// outputs captured at the last sample point
	logic [regwin_pkg::REG_WIDTH-1:0]   got_out;
	logic [regwin_pkg::WIN_BITS-1:0]    got_win;
	logic                               got_trap;

	int errors;
	int test_errors;
	int cur_test;
	int tests_passed;
	int tests_failed;

	regwin_top UUT (
		.Clk            (Clk),
		.arst_n         (arst_n),
		.in             (in),
		.enable         (enable),
		.rw             (rw),
		.r_num          (r_num),
		.save           (save),
		.restore        (restore),
		.wim_write      (wim_write),
		.wim_data       (wim_data),
		.out            (out),
		.current_window (current_window),
		.window_trap    (window_trap)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge Clk);
		#1;
		arst_n = 1'b1;
	end

	// globals map straight through, the windowed region wraps every 64
	function automatic int phys_index(input int unsigned win, input int unsigned r);
		if (r < regwin_pkg::GLOBAL_REGS) begin
			return int'(r);
		end
		return regwin_pkg::GLOBAL_REGS + int'((win * regwin_pkg::WINDOW_STRIDE + r
			- regwin_pkg::GLOBAL_REGS) % regwin_pkg::WINDOWED_REGS);
	endfunction

	task automatic clear_inputs();
		in = '0;
		enable = 1'b0;
		rw = 1'b0;
		r_num = '0;
		save = 1'b0;
		restore = 1'b0;
		wim_write = 1'b0;
		wim_data = '0;
	endtask

	// drive point is 1 ns after the rising edge
	task automatic next_drive_point();
		@(posedge Clk);
		#1;
	endtask

	// sample point is 1 ns before the next rising edge
	task automatic sample_outputs();
		#8;
		got_out = out;
		got_win = current_window;
		got_trap = window_trap;
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
		errors++;
		test_errors++;
	endtask

	task automatic close_test();
		if (test_errors == 0) begin
			$display("test %0d: ok", cur_test);
			tests_passed++;
		end else begin
			$display("test %0d: %0d errors", cur_test, test_errors);
			tests_failed++;
		end
	endtask

	task automatic begin_test(input int n);
		if (n != cur_test) begin
			if (cur_test != 0) begin
				close_test();
			end
			cur_test = n;
			test_errors = 0;
		end
	endtask

	task automatic write_reg(input logic [4:0] r, input logic [31:0] d);
		enable = 1'b1;
		rw = 1'b1;
		r_num = r;
		in = d;
		sample_outputs();
		// r0 writes are dropped
		if (r != 5'd0) begin
			model_regs[phys_index(model_win, 32'(r))] = d;
		end
		next_drive_point();
		clear_inputs();
	endtask

	task automatic read_reg(input logic [4:0] r);
		enable = 1'b1;
		rw = 1'b0;
		r_num = r;
		sample_outputs();
		next_drive_point();
		clear_inputs();
	endtask

	task automatic idle_cycle(input logic [4:0] r);
		r_num = r;
		sample_outputs();
		next_drive_point();
		clear_inputs();
	endtask

	// one move cycle, then sample in the following cycle where a trap shows
	task automatic move_window(input logic do_save);
		int unsigned target;
		save = do_save;
		restore = ~do_save;
		sample_outputs();
		next_drive_point();
		clear_inputs();
		if (do_save) begin
			target = (model_win + regwin_pkg::NUM_WINDOWS - 1) % regwin_pkg::NUM_WINDOWS;
		end else begin
			target = (model_win + 1) % regwin_pkg::NUM_WINDOWS;
		end
		model_trap = model_wim[target];
		if (!model_trap) begin
			model_win = target;
		end
		sample_outputs();
		next_drive_point();
	endtask

	task automatic load_wim(input logic [3:0] d);
		wim_write = 1'b1;
		wim_data = d;
		sample_outputs();
		next_drive_point();
		clear_inputs();
		model_wim = d;
		sample_outputs();
		next_drive_point();
	endtask

	// every address of every window reads zero after reset
	task automatic sweep_after_reset();
		int w;
		int r;
		begin_test(1);
		if (current_window !== 2'd0) report_mismatch("window after reset",
			32'(current_window), 32'd0);
		if (window_trap !== 1'b0) report_mismatch("trap after reset", 32'(window_trap), 32'd0);
		for (w = 0; w < regwin_pkg::NUM_WINDOWS; w++) begin
			for (r = 0; r < regwin_pkg::VIS_REGS; r++) begin
				read_reg(5'(r));
				if (got_out !== 32'd0) report_mismatch($sformatf("w%0d r%0d", w, r),
					got_out, 32'd0);
			end
			move_window(1'b0);
			if (got_win !== 2'((w + 1) % regwin_pkg::NUM_WINDOWS)) report_mismatch(
				"restore in sweep", 32'(got_win), 32'((w + 1) % regwin_pkg::NUM_WINDOWS));
		end
	endtask

	task automatic replay_patterns();
		int fd;
		int n;
		int tnum;
		int lnum;
		logic known;
		string line;
		logic [63:0] op_name;
		logic [31:0] rn;
		logic [31:0] data;
		logic [31:0] expv;
		logic [31:0] ewin;
		logic [31:0] etrap;
		lnum = 0;
		fd = $fopen("verification/regwin_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file verification/regwin_patterns.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				lnum++;
				// 8'h23 is the comment marker
				if (line.len() > 1 && line.getc(0) != 8'h23) begin
					n = $sscanf(line, "%d %s %h %h %h %h %h",
						tnum, op_name, rn, data, expv, ewin, etrap);
					known = 1'b1;
					if (n != 7) begin
						$display("pattern line %0d could not be parsed", lnum);
						errors++;
						known = 1'b0;
					end else begin
						begin_test(tnum);
						if (op_name == "write") write_reg(rn[4:0], data);
						else if (op_name == "read") read_reg(rn[4:0]);
						else if (op_name == "save") move_window(1'b1);
						else if (op_name == "restore") move_window(1'b0);
						else if (op_name == "wim") load_wim(data[3:0]);
						else if (op_name == "idle") idle_cycle(rn[4:0]);
						else begin
							$display("pattern line %0d has an unknown operation", lnum);
							errors++;
							known = 1'b0;
						end
					end
					if (known) begin
						if (got_out !== expv) report_mismatch($sformatf("line %0d out", lnum),
							got_out, expv);
						if (got_win !== ewin[1:0]) report_mismatch(
							$sformatf("line %0d window", lnum), 32'(got_win), ewin);
						if (got_trap !== etrap[0]) report_mismatch(
							$sformatf("line %0d trap", lnum), 32'(got_trap), etrap);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic random_traffic();
		int i;
		int sel;
		logic [4:0] r;
		logic [31:0] d;
		begin_test(6);
		for (i = 0; i < 300; i++) begin
			sel = int'($urandom_range(3, 0));
			r = 5'($urandom_range(31, 0));
			if (sel <= 1) begin
				d = $urandom;
				write_reg(r, d);
			end else if (sel == 2) begin
				read_reg(r);
				if (got_out !== model_regs[phys_index(model_win, 32'(r))]) report_mismatch(
					$sformatf("random read w%0d r%0d", model_win, r), got_out,
					model_regs[phys_index(model_win, 32'(r))]);
			end else begin
				move_window($urandom_range(1, 0) == 1);
				if (got_win !== 2'(model_win)) report_mismatch("random move window",
					32'(got_win), 32'(model_win));
				if (got_trap !== model_trap) report_mismatch("random move trap",
					32'(got_trap), 32'(model_trap));
			end
		end
	endtask

	initial begin
		int i;
		int waited;
		void'($urandom(16));
		clear_inputs();
		errors = 0;
		test_errors = 0;
		cur_test = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (i = 0; i < NUM_PHYS; i++) begin
			model_regs[i] = '0;
		end
		model_win = 0;
		model_wim = '0;
		model_trap = 1'b0;
		waited = 0;
		while (arst_n !== 1'b1 && waited < 50) begin
			@(posedge Clk);
			waited++;
		end
		if (arst_n !== 1'b1) begin
			$display("timeout while waiting for reset release");
			$display("TB FAILED");
			$finish;
		end else begin
			#1;
			sweep_after_reset();
			replay_patterns();
			random_traffic();
			close_test();
			$display("tests ok: %0d, tests with errors: %0d, failed checks: %0d",
				tests_passed, tests_failed, errors);
			if (tests_failed == 0 && errors == 0) begin
				$display("TB PASSED");
			end else begin
				$display("TB FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: verification/regwin_patterns.txt
# columns: test op r_num data expect window trap
# r_num, data, expect in hex; window and trap are the values expected after the operation
2 write   01 11111111 00000000 0 0
2 write   07 77777777 00000000 0 0
2 write   00 deadbeef 00000000 0 0
2 read    00 00000000 00000000 0 0
2 read    01 00000000 11111111 0 0
2 restore 00 00000000 00000000 1 0
2 read    01 00000000 11111111 1 0
2 read    07 00000000 77777777 1 0
2 restore 00 00000000 00000000 2 0
2 read    07 00000000 77777777 2 0
2 restore 00 00000000 00000000 3 0
2 read    01 00000000 11111111 3 0
2 read    00 00000000 00000000 3 0
2 restore 00 00000000 00000000 0 0
3 write   08 a0a0a008 00000000 0 0
3 write   10 c0c0c010 00000000 0 0
3 restore 00 00000000 00000000 1 0
3 write   0f a1a1a10f 00000000 1 0
3 read    10 00000000 00000000 1 0
3 save    00 00000000 00000000 0 0
3 read    1f 00000000 a1a1a10f 0 0
3 read    10 00000000 c0c0c010 0 0
3 save    00 00000000 00000000 3 0
3 read    18 00000000 a0a0a008 3 0
3 read    10 00000000 00000000 3 0
3 restore 00 00000000 00000000 0 0
4 write   09 44440009 00000000 0 0
4 write   11 44440011 00000000 0 0
4 save    00 00000000 00000000 3 0
4 read    19 00000000 44440009 3 0
4 save    00 00000000 00000000 2 0
4 read    11 00000000 00000000 2 0
4 restore 00 00000000 00000000 3 0
4 restore 00 00000000 00000000 0 0
4 read    11 00000000 44440011 0 0
4 read    09 00000000 44440009 0 0
5 wim     00 00000008 00000000 0 0
5 save    00 00000000 00000000 0 1
5 idle    00 00000000 00000000 0 0
5 restore 00 00000000 00000000 1 0
5 wim     00 00000001 00000000 1 0
5 save    00 00000000 00000000 1 1
5 restore 00 00000000 00000000 2 0
5 wim     00 00000000 00000000 2 0
5 save    00 00000000 00000000 1 0
5 save    00 00000000 00000000 0 0
6 write   01 12345678 00000000 0 0
6 idle    01 00000000 00000000 0 0
6 read    01 00000000 12345678 0 0
6 idle    1f 00000000 00000000 0 0
6 write   1f 55555555 00000000 0 0
6 read    1f 00000000 55555555 0 0

// File: compile.f
logic/regwin_pkg.sv
logic/window_control.sv
logic/window_decoder.sv
logic/register_bank.sv
logic/read_select.sv
logic/regwin_top.sv
verification/regwin_checker.sv
verification/regwin_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= regwin_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TB PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
